/* hdl/fme_pixel_pkg.sv */
// ********************
// 8-bit pixels and 8x8 blocks only; row 0 and pixel 0 sit in the top bits
// ********************
package fme_pixel_pkg;

    localparam int PIXEL_WIDTH   = 8;
    localparam int BLK_SIZE      = 8;
    localparam int N_CANDI       = 9;
    localparam int HALF_ROWS     = 4;                            // rows per current-block fetch
    localparam int SATD_WIDTH    = PIXEL_WIDTH + 10;
    localparam int ROW_IDX_WIDTH = $clog2(BLK_SIZE);
    localparam int DIFF_WIDTH    = PIXEL_WIDTH + 1;              // signed pixel difference
    localparam int HAD_WIDTH     = DIFF_WIDTH + ROW_IDX_WIDTH;   // after 8-point row transform
    localparam int ACC_WIDTH     = HAD_WIDTH + ROW_IDX_WIDTH;    // after 8-row column sum

    typedef logic [PIXEL_WIDTH-1:0]       pixel_t;
    typedef pixel_t [0:BLK_SIZE-1]        pel_row_t;        // pixel 0 in top byte
    typedef pel_row_t [0:HALF_ROWS-1]     cur_half_t;       // row 0 in top word
    typedef pel_row_t [0:BLK_SIZE-1]      cur_blk_t;
    typedef pel_row_t [N_CANDI-1:0]       candi_row_vec_t;  // one row per candidate

    typedef logic [ROW_IDX_WIDTH-1:0]     row_idx_t;
    typedef logic signed [DIFF_WIDTH-1:0] diff_t;
    typedef logic signed [HAD_WIDTH-1:0]  had_t;
    typedef logic signed [ACC_WIDTH-1:0]  acc_t;

    typedef logic [SATD_WIDTH-1:0]        satd_t;
    typedef satd_t [N_CANDI-1:0]          satd_vec_t;

    // ********************
    // hadamard sign rule
    // ********************
    // natural (sylvester) order: H[r][u] is -1 when r & u has odd popcount,
    // +1 otherwise; the same rule serves rows and columns
    function automatic logic had_neg(input row_idx_t r, input row_idx_t u);
        return ^(r & u);
    endfunction

endpackage

/* hdl/fme_block_pkg.sv */
// ********************
// block index is the quad-tree (zig-zag) order of 8x8 blocks in a 64x64 CTU
// ********************
package fme_block_pkg;

    localparam int BLK_IDX_WIDTH = 6;
    localparam int POS8_WIDTH    = 3;   // 8x8 grid position
    localparam int POS4_WIDTH    = 4;   // 4x4 grid position
    localparam int POS_IDX_WIDTH = 5;

    // one quad-tree level, x in bit 0 and y in bit 1
    typedef struct packed {
        logic y;
        logic x;
    } quad_t;

    typedef struct packed {
        quad_t q32;   // 32x32 quadrant
        quad_t q16;
        quad_t q08;
    } quad_idx_t;

    typedef union packed {
        logic [BLK_IDX_WIDTH-1:0] flat;
        quad_idx_t                quad;
    } blk_idx_u;

    // fetch address toward the current-LCU buffer
    typedef struct packed {
        logic [POS4_WIDTH-1:0]    x4;
        logic [POS4_WIDTH-1:0]    y4;
        logic [POS_IDX_WIDTH-1:0] idx4;
    } cur_pos_t;

endpackage

/* hdl/fme_satd_8x8.sv */
// ********************
// rows must arrive in order 0..7; result is (sum |coef| + 2) >> 2
// ********************
`timescale 1ns/1ps

module fme_satd_8x8 (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     start_i,
    input  fme_pixel_pkg::cur_blk_t  cur_blk_i,
    input  logic                     row_valid_i,
    input  fme_pixel_pkg::pel_row_t  row_i,
    output fme_pixel_pkg::satd_t     satd_o,
    output logic                     done_o
);

    fme_pixel_pkg::row_idx_t row_cnt_q;
    fme_pixel_pkg::pel_row_t cur_row;
    fme_pixel_pkg::diff_t    diff [fme_pixel_pkg::BLK_SIZE];
    fme_pixel_pkg::had_t     had  [fme_pixel_pkg::BLK_SIZE];

    // acc_q[v][u], v is the column-transform index, u the row-transform index
    fme_pixel_pkg::acc_t     acc_q [fme_pixel_pkg::BLK_SIZE][fme_pixel_pkg::BLK_SIZE];

    logic                    last_row_q;
    fme_pixel_pkg::satd_t    abs_sum;

    // ********************
    // row counter
    // ********************
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            row_cnt_q <= '0;
        else if (start_i)
            row_cnt_q <= '0;
        else if (row_valid_i)
            row_cnt_q <= row_cnt_q + 1'b1;   // wraps after row 7
    end

    assign cur_row = cur_blk_i[row_cnt_q];

    // ********************
    // row difference and transform
    // ********************
    always_comb begin
        for (int j = 0; j < fme_pixel_pkg::BLK_SIZE; j++) begin
            diff[j] = fme_pixel_pkg::diff_t'({1'b0, row_i[j]})
                    - fme_pixel_pkg::diff_t'({1'b0, cur_row[j]});
        end
    end

    always_comb begin
        fme_pixel_pkg::had_t sum;
        for (int u = 0; u < fme_pixel_pkg::BLK_SIZE; u++) begin
            sum = '0;
            for (int j = 0; j < fme_pixel_pkg::BLK_SIZE; j++) begin
                if (fme_pixel_pkg::had_neg(fme_pixel_pkg::row_idx_t'(j),
                                           fme_pixel_pkg::row_idx_t'(u)))
                    sum = sum - fme_pixel_pkg::had_t'(diff[j]);
                else
                    sum = sum + fme_pixel_pkg::had_t'(diff[j]);
            end
            had[u] = sum;
        end
    end

    // ********************
    // column accumulation
    // ********************
    // each incoming row r contributes H[r][v] * had[u] to coefficient (v, u)
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int v = 0; v < fme_pixel_pkg::BLK_SIZE; v++) begin
                for (int u = 0; u < fme_pixel_pkg::BLK_SIZE; u++) begin
                    acc_q[v][u] <= '0;
                end
            end
        end else if (start_i) begin
            for (int v = 0; v < fme_pixel_pkg::BLK_SIZE; v++) begin
                for (int u = 0; u < fme_pixel_pkg::BLK_SIZE; u++) begin
                    acc_q[v][u] <= '0;
                end
            end
        end else if (row_valid_i) begin
            for (int v = 0; v < fme_pixel_pkg::BLK_SIZE; v++) begin
                for (int u = 0; u < fme_pixel_pkg::BLK_SIZE; u++) begin
                    if (fme_pixel_pkg::had_neg(row_cnt_q, fme_pixel_pkg::row_idx_t'(v)))
                        acc_q[v][u] <= acc_q[v][u] - fme_pixel_pkg::acc_t'(had[u]);
                    else
                        acc_q[v][u] <= acc_q[v][u] + fme_pixel_pkg::acc_t'(had[u]);
                end
            end
        end
    end

    // set on the edge that takes in row 7
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            last_row_q <= 1'b0;
        else
            last_row_q <= row_valid_i && !start_i && (row_cnt_q == '1);
    end

    // ********************
    // absolute sum and result
    // ********************
    always_comb begin
        fme_pixel_pkg::acc_t mag;
        abs_sum = '0;
        for (int v = 0; v < fme_pixel_pkg::BLK_SIZE; v++) begin
            for (int u = 0; u < fme_pixel_pkg::BLK_SIZE; u++) begin
                mag     = (acc_q[v][u] < 0) ? -acc_q[v][u] : acc_q[v][u];
                abs_sum = abs_sum + fme_pixel_pkg::satd_t'(mag);
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            satd_o <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= last_row_q;   // single-cycle pulse
            if (last_row_q)
                satd_o <= (abs_sum + fme_pixel_pkg::satd_t'(2)) >> 2;   // holds to next block
        end
    end

endmodule

/* hdl/fme_cur_buf.sv */
// ********************
// at most two block indices in flight; halves alternate 0-3, 4-7 from reset
// ********************
`timescale 1ns/1ps

module fme_cur_buf (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      satd_start_i,
    input  fme_block_pkg::blk_idx_u   blk_idx_i,
    input  logic                      ip_ready_i,
    input  fme_pixel_pkg::cur_half_t  cur_pel_i,
    input  logic                      satd_done_i,
    output logic                      cur_rden_o,
    output fme_block_pkg::cur_pos_t   cur_pos_o,
    output fme_block_pkg::blk_idx_u   blk_idx_o,
    output fme_pixel_pkg::cur_blk_t   cur_blk_o
);

    logic [fme_block_pkg::BLK_IDX_WIDTH-1:0] slot0_q;
    logic [fme_block_pkg::BLK_IDX_WIDTH-1:0] slot1_q;
    logic                                    idx_in_q;    // next slot to write
    logic                                    idx_out_q;   // oldest unretired slot
    fme_block_pkg::blk_idx_u                 cur_idx;     // most recently accepted
    logic [fme_block_pkg::POS8_WIDTH-1:0]    x8;
    logic [fme_block_pkg::POS8_WIDTH-1:0]    y8;

    logic                                    half_q;      // 1: rows 4-7 fetched next
    logic                                    cap_vld_q;
    fme_pixel_pkg::cur_half_t                half0_q;     // rows 0-3
    fme_pixel_pkg::cur_half_t                half1_q;     // rows 4-7

    // ********************
    // block index ping-pong
    // ********************
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            idx_in_q <= 1'b0;
            slot0_q  <= '0;
            slot1_q  <= '0;
        end else if (satd_start_i) begin
            idx_in_q <= ~idx_in_q;
            if (!idx_in_q)
                slot0_q <= blk_idx_i.flat;
            else
                slot1_q <= blk_idx_i.flat;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            idx_out_q <= 1'b0;
        else if (satd_done_i)
            idx_out_q <= ~idx_out_q;
    end

    always_comb begin
        cur_idx.flat   = idx_in_q ? slot0_q : slot1_q;
        blk_idx_o.flat = idx_out_q ? slot1_q : slot0_q;
    end

    // zig-zag to raster, one bit per quad-tree level
    assign x8 = {cur_idx.quad.q32.x, cur_idx.quad.q16.x, cur_idx.quad.q08.x};
    assign y8 = {cur_idx.quad.q32.y, cur_idx.quad.q16.y, cur_idx.quad.q08.y};

    // ********************
    // current block fetch
    // ********************
    assign cur_rden_o     = ip_ready_i;
    assign cur_pos_o.x4   = {x8, 1'b0};
    assign cur_pos_o.y4   = {y8, 1'b0};
    assign cur_pos_o.idx4 = {2'b00, half_q, 2'b00};   // 0 or 4

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            half_q    <= 1'b0;
            cap_vld_q <= 1'b0;
        end else begin
            cap_vld_q <= cur_rden_o;   // data lands one cycle after the read
            if (cur_rden_o)
                half_q <= ~half_q;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            half0_q <= '0;
            half1_q <= '0;
        end else if (cap_vld_q) begin
            if (half_q)
                half0_q <= cur_pel_i;   // toggled already, so this was the 0-3 read
            else
                half1_q <= cur_pel_i;
        end
    end

    assign cur_blk_o = {half0_q, half1_q};

endmodule

/* hdl/fme_satd_gen.sv */
// ********************
// no back-pressure; candidate N_CANDI-1 must be the last to finish its rows
// ********************
`timescale 1ns/1ps

module fme_satd_gen (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                satd_start_i,
    input  fme_block_pkg::blk_idx_u             blk_idx_i,
    input  logic                                ip_ready_i,
    input  fme_pixel_pkg::cur_half_t            cur_pel_i,
    input  logic [fme_pixel_pkg::N_CANDI-1:0]   candi_valid_i,
    input  fme_pixel_pkg::candi_row_vec_t       candi_pel_i,
    output logic                                cur_rden_o,
    output fme_block_pkg::cur_pos_t             cur_pos_o,
    output fme_block_pkg::blk_idx_u             blk_idx_o,
    output fme_pixel_pkg::satd_vec_t            satd_o,
    output logic                                satd_valid_o
);

    fme_pixel_pkg::cur_blk_t cur_blk;   // full current block, shared by all units

    // ********************
    // current block buffer
    // ********************
    fme_cur_buf u_cur_buf (
        .clk          (clk),
        .rstn         (rstn),
        .satd_start_i (satd_start_i),
        .blk_idx_i    (blk_idx_i),
        .ip_ready_i   (ip_ready_i),
        .cur_pel_i    (cur_pel_i),
        .satd_done_i  (satd_valid_o),   // retires the output slot
        .cur_rden_o   (cur_rden_o),
        .cur_pos_o    (cur_pos_o),
        .blk_idx_o    (blk_idx_o),
        .cur_blk_o    (cur_blk)
    );

    // ********************
    // one SATD unit per candidate
    // ********************
    for (genvar g = 0; g < fme_pixel_pkg::N_CANDI; g++) begin : g_candi
        if (g == fme_pixel_pkg::N_CANDI - 1) begin : g_last
            // last candidate finishes last, its done marks the whole set
            fme_satd_8x8 u_satd (
                .clk         (clk),
                .rstn        (rstn),
                .start_i     (satd_start_i),
                .cur_blk_i   (cur_blk),
                .row_valid_i (candi_valid_i[g]),
                .row_i       (candi_pel_i[g]),
                .satd_o      (satd_o[g]),
                .done_o      (satd_valid_o)
            );
        end else begin : g_other
            fme_satd_8x8 u_satd (
                .clk         (clk),
                .rstn        (rstn),
                .start_i     (satd_start_i),
                .cur_blk_i   (cur_blk),
                .row_valid_i (candi_valid_i[g]),
                .row_i       (candi_pel_i[g]),
                .satd_o      (satd_o[g]),
                .done_o      ()
            );
        end
    end

endmodule

/* bench/fme_satd_gen_assertions.sv */
// ********************
// bound into the top level; counts the last candidate's rows on its own
// ********************
`timescale 1ns/1ps

module fme_satd_gen_assertions (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                satd_start_i,
    input  logic                                ip_ready_i,
    input  logic [fme_pixel_pkg::N_CANDI-1:0]   candi_valid_i,
    input  fme_block_pkg::cur_pos_t             cur_pos_o,
    input  logic                                satd_valid_o
);

    logic [2:0]  last_rows_q;   // rows taken by the last candidate
    logic        last_row;
    int unsigned fail_cnt = 0;

    assign last_row = candi_valid_i[fme_pixel_pkg::N_CANDI-1] && !satd_start_i
                      && (last_rows_q == 3'd7);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            last_rows_q <= '0;
        else if (satd_start_i)
            last_rows_q <= '0;
        else if (candi_valid_i[fme_pixel_pkg::N_CANDI-1])
            last_rows_q <= last_rows_q + 3'd1;
    end

    // ********************
    // result pulse
    // ********************
    a_valid_pulse: assert property (@(posedge clk) disable iff (!rstn)
                                    satd_valid_o |=> !satd_valid_o)
        else begin
            $error("satd_valid_o high two cycles in a row");
            fail_cnt++;
        end

    a_valid_after_row: assert property (@(posedge clk) disable iff (!rstn)
                                        last_row |-> ##2 satd_valid_o)
        else begin
            $error("satd_valid_o missing two edges after the last row");
            fail_cnt++;
        end

    a_valid_cause: assert property (@(posedge clk) disable iff (!rstn)
                                    satd_valid_o |-> $past(last_row, 2))
        else begin
            $error("satd_valid_o without a last row two edges before");
            fail_cnt++;
        end

    // fetch address only moves on a read or a new block
    a_pos_stable: assert property (@(posedge clk) disable iff (!rstn)
                                   !ip_ready_i && !satd_start_i |=> $stable(cur_pos_o))
        else begin
            $error("cur_pos_o changed with no read and no start");
            fail_cnt++;
        end

endmodule

bind fme_satd_gen fme_satd_gen_assertions u_assertions (
    .clk           (clk),
    .rstn          (rstn),
    .satd_start_i  (satd_start_i),
    .ip_ready_i    (ip_ready_i),
    .candi_valid_i (candi_valid_i),
    .cur_pos_o     (cur_pos_o),
    .satd_valid_o  (satd_valid_o)
);

/* bench/fme_satd_gen_tb.sv */
// ********************
// random blocks from a fixed-seed LFSR; the last candidate always ends its rows last
// ********************
`timescale 1ns/1ps

module fme_satd_gen_tb;

    localparam int N_BLOCKS         = 12;
    localparam int CYCLES_PER_BLOCK = 40;
    localparam int RESET_CYCLES     = 4;
    localparam int TIMEOUT_CYCLES   = N_BLOCKS * CYCLES_PER_BLOCK + RESET_CYCLES;

    logic                                 clk;
    logic                                 rstn;
    logic                                 satd_start_i;
    fme_block_pkg::blk_idx_u              blk_idx_i;
    logic                                 ip_ready_i;
    fme_pixel_pkg::cur_half_t             cur_pel_i;
    logic [fme_pixel_pkg::N_CANDI-1:0]    candi_valid_i;
    fme_pixel_pkg::candi_row_vec_t        candi_pel_i;
    logic                                 cur_rden_o;
    fme_block_pkg::cur_pos_t              cur_pos_o;
    fme_block_pkg::blk_idx_u              blk_idx_o;
    fme_pixel_pkg::satd_vec_t             satd_o;
    logic                                 satd_valid_o;

    logic [15:0]              lfsr_q;
    fme_pixel_pkg::cur_blk_t  cur_data;
    fme_pixel_pkg::cur_blk_t  cand_data [fme_pixel_pkg::N_CANDI];
    fme_pixel_pkg::satd_vec_t exp_satd_mem [N_BLOCKS];   // one entry per started block
    logic [5:0]               exp_idx_mem [N_BLOCKS];
    fme_pixel_pkg::satd_vec_t exp_satd;                  // result now due
    fme_block_pkg::blk_idx_u  exp_idx;
    fme_block_pkg::cur_pos_t  exp_pos;
    logic                     half_sel;                  // next read is rows 4-7
    int                       blk_cnt;
    int                       res_cnt;
    int                       cycle_cnt;

    fme_satd_gen uut (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // ********************
    // error reporting
    // ********************
    task automatic abort_run();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input logic [255:0] expv,
                                input logic [255:0] gotv);
        $display("ERR %s expected %0h got %0h", name, expv, gotv);
        abort_run();
    endtask

    task automatic report_text(input string msg);
        $display("%s", msg);
        abort_run();
    endtask

    // ********************
    // random data
    // ********************
    function automatic logic lfsr_bit();
        logic fb;
        fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];   // taps 16 14 13 11
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[6:0], lfsr_bit()};
        return v;
    endfunction

    // direct 2-D transform, sign from the popcount parity of row and column
    function automatic fme_pixel_pkg::satd_t model_satd(input fme_pixel_pkg::cur_blk_t cur,
                                                        input fme_pixel_pkg::cur_blk_t cand);
        int coef;
        int term;
        int total;
        total = 0;
        for (int v = 0; v < fme_pixel_pkg::BLK_SIZE; v++) begin
            for (int u = 0; u < fme_pixel_pkg::BLK_SIZE; u++) begin
                coef = 0;
                for (int i = 0; i < fme_pixel_pkg::BLK_SIZE; i++) begin
                    for (int j = 0; j < fme_pixel_pkg::BLK_SIZE; j++) begin
                        term = int'(cand[i][j]) - int'(cur[i][j]);
                        if ((($countones(i & v) + $countones(j & u)) % 2) != 0)
                            coef = coef - term;
                        else
                            coef = coef + term;
                    end
                end
                total = total + ((coef < 0) ? -coef : coef);
            end
        end
        return fme_pixel_pkg::satd_t'((total + 2) >> 2);
    endfunction

    task automatic fill_block(input bit corner);
        for (int r = 0; r < fme_pixel_pkg::BLK_SIZE; r++)
            for (int c = 0; c < fme_pixel_pkg::BLK_SIZE; c++)
                cur_data[r][c] = corner ? 8'h00 : rand_bits(8);
        for (int k = 0; k < fme_pixel_pkg::N_CANDI; k++)
            for (int r = 0; r < fme_pixel_pkg::BLK_SIZE; r++)
                for (int c = 0; c < fme_pixel_pkg::BLK_SIZE; c++)
                    cand_data[k][r][c] = rand_bits(8);
        if (corner) begin
            cand_data[0] = cur_data;   // identical block
            cand_data[1] = '1;         // all 255 against all 0
        end
    endtask

    // ********************
    // stimulus
    // ********************
    task automatic drive_idle();
        satd_start_i  = 1'b0;
        ip_ready_i    = 1'b0;
        candi_valid_i = '0;
    endtask

    task automatic start_block(input logic [5:0] idx);
        @(negedge clk);
        drive_idle();
        satd_start_i   = 1'b1;
        blk_idx_i.flat = idx;
        exp_pos.x4     = {idx[4], idx[2], idx[0], 1'b0};
        exp_pos.y4     = {idx[5], idx[3], idx[1], 1'b0};
    endtask

    // two reads back to back, data follows each read by one cycle
    task automatic fetch_cur();
        for (int n = 0; n < 3; n++) begin
            @(negedge clk);
            drive_idle();
            if (n < 2) begin
                ip_ready_i   = 1'b1;
                exp_pos.idx4 = half_sel ? 5'd4 : 5'd0;
                half_sel     = ~half_sel;
            end
            if (n > 0)
                for (int r = 0; r < fme_pixel_pkg::HALF_ROWS; r++)
                    cur_pel_i[r] = cur_data[(n - 1) * fme_pixel_pkg::HALF_ROWS + r];
        end
    endtask

    task automatic send_rows();
        int sent [fme_pixel_pkg::N_CANDI];
        int last;
        bit others_done;
        last = fme_pixel_pkg::N_CANDI - 1;
        foreach (sent[k])
            sent[k] = 0;
        while (sent[last] < fme_pixel_pkg::BLK_SIZE) begin
            @(negedge clk);
            drive_idle();
            others_done = 1'b1;
            for (int k = 0; k < last; k++) begin
                if (sent[k] < fme_pixel_pkg::BLK_SIZE && rand_bits(2) != 8'd0) begin
                    candi_valid_i[k] = 1'b1;
                    candi_pel_i[k]   = cand_data[k][sent[k]];
                    sent[k]++;
                end
                if (sent[k] < fme_pixel_pkg::BLK_SIZE)
                    others_done = 1'b0;
            end
            // the eighth row of the last candidate waits for all others
            if ((sent[last] < 7 || others_done) && rand_bits(2) != 8'd0) begin
                candi_valid_i[last] = 1'b1;
                candi_pel_i[last]   = cand_data[last][sent[last]];
                sent[last]++;
            end
        end
    endtask

    task automatic wait_results(input int target);
        while (res_cnt < target) begin
            @(negedge clk);
            drive_idle();
        end
    endtask

    task automatic run_block(input logic [5:0] idx, input bit corner, input bit wait_done);
        fill_block(corner);
        for (int k = 0; k < fme_pixel_pkg::N_CANDI; k++)
            exp_satd_mem[blk_cnt][k] = model_satd(cur_data, cand_data[k]);
        if (corner) begin
            exp_satd_mem[blk_cnt][0] = '0;
            exp_satd_mem[blk_cnt][1] = fme_pixel_pkg::satd_t'((64 * 255 + 2) >> 2);  // DC only
        end
        exp_idx_mem[blk_cnt] = idx;
        blk_cnt++;
        start_block(idx);
        fetch_cur();
        send_rows();
        if (wait_done)
            wait_results(blk_cnt);
    endtask

    // ********************
    // checks
    // ********************
    always @(negedge clk) begin
        if (satd_valid_o) begin
            if (res_cnt >= N_BLOCKS) begin
                report_text("satd_valid_o rose with no block left to finish");
            end else begin
                exp_satd     = exp_satd_mem[res_cnt];
                exp_idx.flat = exp_idx_mem[res_cnt];
                res_cnt++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES)
            report_text("timeout, the run passed its cycle limit");
    end

    a_reset: assert property (@(posedge clk) !rstn |-> !satd_valid_o && !cur_rden_o)
        else report_text("satd_valid_o or cur_rden_o high during reset");
    a_rden: assert property (@(posedge clk) cur_rden_o == ip_ready_i)
        else report_value("cur_rden_o", 256'($sampled(ip_ready_i)), 256'($sampled(cur_rden_o)));
    a_pos: assert property (@(posedge clk) disable iff (!rstn) cur_rden_o |-> cur_pos_o == exp_pos)
        else report_value("cur_pos_o", 256'(exp_pos), 256'($sampled(cur_pos_o)));
    a_satd: assert property (@(posedge clk) disable iff (!rstn) satd_valid_o |-> satd_o == exp_satd)
        else report_value("satd_o", 256'(exp_satd), 256'($sampled(satd_o)));
    a_idx: assert property (@(posedge clk) disable iff (!rstn)
                            satd_valid_o |-> blk_idx_o.flat == exp_idx.flat)
        else report_value("blk_idx_o", 256'(exp_idx.flat), 256'($sampled(blk_idx_o.flat)));

    // ********************
    // main sequence
    // ********************
    initial begin
        lfsr_q      = 16'd39068;
        rstn        = 1'b0;
        drive_idle();
        blk_idx_i   = '0;
        cur_pel_i   = '0;
        candi_pel_i = '0;
        exp_satd    = '0;
        exp_idx     = '0;
        exp_pos     = '0;
        half_sel    = 1'b0;
        blk_cnt     = 0;
        res_cnt     = 0;
        cycle_cnt   = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        rstn = 1'b1;
        repeat (2) @(negedge clk);

        run_block(6'h00, 1'b1, 1'b1);
        repeat (9) run_block(6'(rand_bits(6)), 1'b0, 1'b1);
        run_block(6'h2d, 1'b0, 1'b0);   // second start lands before this result
        run_block(6'h12, 1'b0, 1'b1);
        repeat (3) @(negedge clk);

        if (res_cnt == N_BLOCKS && uut.u_assertions.fail_cnt == 0) begin
            $display("No errors");
            $finish;
        end else begin
            report_text("results missing or a protocol assertion failed");
        end
    end

endmodule

/* fme_satd_gen.f */
hdl/fme_pixel_pkg.sv
hdl/fme_block_pkg.sv
hdl/fme_satd_8x8.sv
hdl/fme_cur_buf.sv
hdl/fme_satd_gen.sv
bench/fme_satd_gen_assertions.sv
bench/fme_satd_gen_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the SATD testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --assert --timing \
    --top-module fme_satd_gen_tb \
    -f fme_satd_gen.f

./obj_dir/Vfme_satd_gen_tb 2>&1 | tee "$LOG"

if grep -q "^No errors$" "$LOG"; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
